/* hw/conv_config.svh */
`ifndef CONV_CONFIG_SVH
`define CONV_CONFIG_SVH

// Greyscale pixel depth in bits.
`define CONV_BIT_DEPTH 8

// Image geometry. The memory holds exactly one image of this size.
`define CONV_IMG_WIDTH  28
`define CONV_IMG_HEIGHT 28

// Enough to address 28 * 28 = 784 pixels.
`define CONV_ADDR_WIDTH 10

`define CONV_COEF_WIDTH 8  // Signed kernel coefficient.

// Nine products of an unsigned 8-bit pixel and a signed 8-bit coefficient
// stay within +/- 2^20, so 21 bits never overflow.
`define CONV_ACC_WIDTH 21

`endif

/* hw/conv_pkg.sv */
`include "conv_config.svh"

package conv_pkg;

    typedef logic [`CONV_BIT_DEPTH-1:0]  pixel_t;
    typedef logic [`CONV_ADDR_WIDTH-1:0] addr_t;  // Row times width plus column.

    typedef logic [$clog2(`CONV_IMG_HEIGHT)-1:0] row_t;
    typedef logic [$clog2(`CONV_IMG_WIDTH)-1:0]  col_t;

    typedef logic signed [`CONV_COEF_WIDTH-1:0] coef_t;
    typedef logic signed [`CONV_ACC_WIDTH-1:0]  acc_t;

    // One column of the window, as read from three adjacent rows.
    typedef struct packed {
        pixel_t top;
        pixel_t mid;
        pixel_t bot;
    } window_col_t;

    typedef struct packed {
        window_col_t left;
        window_col_t centre;
        window_col_t right;
    } window_t;

    // Coefficients named by kernel row and column, row-major.
    typedef struct packed {
        coef_t r0c0;
        coef_t r0c1;
        coef_t r0c2;
        coef_t r1c0;
        coef_t r1c1;
        coef_t r1c2;
        coef_t r2c0;
        coef_t r2c1;
        coef_t r2c2;
    } kernel_t;

    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        SHIFT,
        DONE
    } load_state_t;

endpackage

/* hw/image_mem.sv */
`timescale 1ns/1ps
`include "conv_config.svh"

module image_mem (
    input  logic                  clk,
    input  logic                  we,
    input  conv_pkg::addr_t       waddr,
    input  conv_pkg::pixel_t      wdata,
    input  logic                  rd_en,
    input  conv_pkg::addr_t       raddr_top,
    input  conv_pkg::addr_t       raddr_mid,
    input  conv_pkg::addr_t       raddr_bot,
    output conv_pkg::window_col_t rdata
);
    import conv_pkg::*;

    localparam int DEPTH = `CONV_IMG_WIDTH * `CONV_IMG_HEIGHT;

    pixel_t mem [DEPTH];

    // Single write port, one pixel per cycle.
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Three reads share one enable so the column arrives as a unit.
    // A read that hits the address written on the same edge sees the old pixel.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rdata.top <= mem[raddr_top];
            rdata.mid <= mem[raddr_mid];
            rdata.bot <= mem[raddr_bot];
        end
    end

endmodule

/* hw/load_buffer.sv */
`timescale 1ns/1ps
`include "conv_config.svh"

module load_buffer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  conv_pkg::row_t        row_num,
    output logic                  rd_en,
    output conv_pkg::addr_t       raddr_top,
    output conv_pkg::addr_t       raddr_mid,
    output conv_pkg::addr_t       raddr_bot,
    input  conv_pkg::window_col_t rdata,
    output conv_pkg::window_t     window,
    output logic                  win_valid,
    output conv_pkg::col_t        win_col,
    output logic                  busy,
    output logic                  done
);
    import conv_pkg::*;

    localparam col_t  LAST_COL   = col_t'(`CONV_IMG_WIDTH - 1);
    localparam addr_t ROW_STRIDE = addr_t'(`CONV_IMG_WIDTH);

    load_state_t state;
    load_state_t next_state;
    addr_t       base_addr;   // First pixel of the top row.
    col_t        rd_col;      // Column read in the current cycle.
    logic        rd_valid;    // rdata holds a column returned on the last edge.
    col_t        shift_cnt;   // Columns of this run that came back before the one in rdata.
    window_col_t centre_col;
    window_col_t left_col;

    assign base_addr = addr_t'(row_num) * ROW_STRIDE;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (start) begin
                    next_state = LOAD;
                end
            end
            LOAD: begin
                if (rd_col == LAST_COL) begin
                    next_state = SHIFT;
                end
            end
            SHIFT:   next_state = DONE;  // The last read comes back here.
            DONE:    next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    assign rd_en = (state == LOAD);
    assign busy  = (state != IDLE);

    // Row addresses are set only from IDLE, so a late start cannot move them.
    always_ff @(posedge clk) begin
        if (rst) begin
            raddr_top <= '0;
            raddr_mid <= '0;
            raddr_bot <= '0;
            rd_col    <= '0;
        end else if (state == IDLE && start) begin
            raddr_top <= base_addr;
            raddr_mid <= base_addr + ROW_STRIDE;
            raddr_bot <= base_addr + ROW_STRIDE + ROW_STRIDE;
            rd_col    <= '0;
        end else if (rd_en) begin
            raddr_top <= raddr_top + 1'b1;
            raddr_mid <= raddr_mid + 1'b1;
            raddr_bot <= raddr_bot + 1'b1;
            rd_col    <= rd_col + 1'b1;
        end
    end

    // Memory data lags the read by one edge.
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;
        end
    end

    // The right column is the memory register itself. Each returned column
    // moves on into centre and then left.
    always_ff @(posedge clk) begin
        if (rst) begin
            centre_col <= '0;
            left_col   <= '0;
        end else if (rd_valid) begin
            centre_col <= rdata;
            left_col   <= centre_col;
        end
    end

    assign window.left   = left_col;
    assign window.centre = centre_col;
    assign window.right  = rdata;

    // Two columns must already be in place before the window is full.
    assign win_valid = rd_valid && (shift_cnt >= col_t'(2));

    always_ff @(posedge clk) begin
        if (rst) begin
            shift_cnt <= '0;
            win_col   <= '0;
        end else if (state == IDLE && start) begin
            shift_cnt <= '0;
            win_col   <= '0;
        end else begin
            if (rd_valid) begin
                shift_cnt <= shift_cnt + 1'b1;
            end
            if (win_valid) begin
                win_col <= win_col + 1'b1;  // Tracks shift_cnt minus two.
            end
        end
    end

    // done lands one cycle after DONE, right behind the last MAC result.
    always_ff @(posedge clk) begin
        if (rst) begin
            done <= 1'b0;
        end else begin
            done <= (state == DONE);
        end
    end

endmodule

/* hw/conv_window_mac.sv */
`timescale 1ns/1ps
`include "conv_config.svh"

module conv_window_mac (
    input  logic              clk,
    input  logic              rst,
    input  conv_pkg::window_t window,
    input  logic              win_valid,
    input  conv_pkg::col_t    win_col,
    input  conv_pkg::kernel_t kernel,
    output conv_pkg::acc_t    result,
    output conv_pkg::col_t    result_col,
    output logic              result_valid
);
    import conv_pkg::*;

    // An unsigned pixel needs one extra bit once it is treated as signed.
    localparam int PROD_WIDTH = `CONV_BIT_DEPTH + 1 + `CONV_COEF_WIDTH;

    typedef logic signed [PROD_WIDTH-1:0] prod_t;

    pixel_t pix  [9];
    coef_t  coef [9];
    prod_t  prod [9];
    acc_t   sum;

    // Taps in row-major order, matching the kernel field order.
    assign pix[0] = window.left.top;
    assign pix[1] = window.centre.top;
    assign pix[2] = window.right.top;
    assign pix[3] = window.left.mid;
    assign pix[4] = window.centre.mid;
    assign pix[5] = window.right.mid;
    assign pix[6] = window.left.bot;
    assign pix[7] = window.centre.bot;
    assign pix[8] = window.right.bot;

    assign coef[0] = kernel.r0c0;
    assign coef[1] = kernel.r0c1;
    assign coef[2] = kernel.r0c2;
    assign coef[3] = kernel.r1c0;
    assign coef[4] = kernel.r1c1;
    assign coef[5] = kernel.r1c2;
    assign coef[6] = kernel.r2c0;
    assign coef[7] = kernel.r2c1;
    assign coef[8] = kernel.r2c2;

    always_comb begin
        sum = '0;
        for (int i = 0; i < 9; i++) begin
            prod[i] = $signed({1'b0, pix[i]}) * coef[i];
            sum     = sum + acc_t'(prod[i]);  // Sign-extends each product.
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= win_valid;
        end
    end

    // The sum and its column stay put between valid windows.
    always_ff @(posedge clk) begin
        if (win_valid) begin
            result     <= sum;
            result_col <= win_col;
        end
    end

endmodule

/* hw/conv_row_engine.sv */
`timescale 1ns/1ps

module conv_row_engine (
    input  logic              clk,
    input  logic              rst,
    input  logic              img_we,
    input  conv_pkg::addr_t   img_waddr,
    input  conv_pkg::pixel_t  img_wdata,
    input  logic              start,
    input  conv_pkg::row_t    row_num,
    input  conv_pkg::kernel_t kernel,
    output conv_pkg::acc_t    result,
    output conv_pkg::col_t    result_col,
    output logic              result_valid,
    output logic              busy,
    output logic              done
);
    import conv_pkg::*;

    logic        rd_en;
    addr_t       raddr_top;
    addr_t       raddr_mid;
    addr_t       raddr_bot;
    window_col_t rdata;      // Returned column, also the right edge of the window.
    window_t     window;
    logic        win_valid;
    col_t        win_col;

    image_mem i_mem (
        .clk       (clk),
        .we        (img_we),
        .waddr     (img_waddr),
        .wdata     (img_wdata),
        .rd_en     (rd_en),
        .raddr_top (raddr_top),
        .raddr_mid (raddr_mid),
        .raddr_bot (raddr_bot),
        .rdata     (rdata)
    );

    load_buffer i_load (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .row_num   (row_num),
        .rd_en     (rd_en),
        .raddr_top (raddr_top),
        .raddr_mid (raddr_mid),
        .raddr_bot (raddr_bot),
        .rdata     (rdata),
        .window    (window),
        .win_valid (win_valid),
        .win_col   (win_col),
        .busy      (busy),
        .done      (done)
    );

    // One cycle of latency, so done still trails the last result.
    conv_window_mac i_mac (
        .clk          (clk),
        .rst          (rst),
        .window       (window),
        .win_valid    (win_valid),
        .win_col      (win_col),
        .kernel       (kernel),
        .result       (result),
        .result_col   (result_col),
        .result_valid (result_valid)
    );

endmodule

/* verification/conv_chk.sv */
`timescale 1ns/1ps

module conv_chk (
    input logic                  clk,
    input logic                  rst,
    input logic                  start,
    input logic                  busy,
    input logic                  done,
    input logic                  rd_en,
    input logic                  win_valid,
    input conv_pkg::addr_t       raddr_top,
    input conv_pkg::addr_t       raddr_mid,
    input conv_pkg::addr_t       raddr_bot,
    input conv_pkg::load_state_t state
);
    import conv_pkg::*;

    int assert_failures = 0;

    done_one_cycle: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else begin
            $error("done stayed high for more than one cycle");
            assert_failures++;
        end

    valid_only_busy: assert property (@(posedge clk) disable iff (rst) win_valid |-> busy)
        else begin
            $error("win_valid is high while the load buffer is not busy");
            assert_failures++;
        end

    // Without a start the FSM stays in IDLE and issues no read.
    no_read_idle: assert property (@(posedge clk) disable iff (rst)
        (state == IDLE && !start) |=> !rd_en)
        else begin
            $error("a read was issued from IDLE without a start");
            assert_failures++;
        end

    // A late start may only let the addresses step on by the normal read increment.
    late_start_ignored: assert property (@(posedge clk) disable iff (rst)
        (start && busy) |=> (raddr_top == $past(raddr_top) + addr_t'($past(rd_en))) &&
                            (raddr_mid == $past(raddr_mid) + addr_t'($past(rd_en))) &&
                            (raddr_bot == $past(raddr_bot) + addr_t'($past(rd_en))))
        else begin
            $error("start while busy moved the row addresses");
            assert_failures++;
        end

endmodule

/* verification/conv_monitor.sv */
`timescale 1ns/1ps
`include "conv_config.svh"

module conv_monitor (
    input logic           clk,
    input logic           rst,
    input conv_pkg::acc_t result,
    input conv_pkg::col_t result_col,
    input logic           result_valid,
    input logic           busy,
    input logic           done,
    input int             test_id
);
    import conv_pkg::*;

    localparam int RESULTS_PER_RUN = `CONV_IMG_WIDTH - 2;

    int   exp_q [$];       // Expected sums in column order.
    int   expected;
    int   beats       = 0;  // Result beats seen in the current run.
    int   run_errors  = 0;
    int   pass_count  = 0;
    int   fail_count  = 0;
    int   done_id     = 0;  // Test that the pending verdict belongs to.
    logic verdict_due = 1'b0;

    task automatic push_expected(input int value);
        exp_q.push_back(value);
    endtask

    // Used when a run never finishes, so its leftovers do not leak into later runs.
    task automatic record_failure();
        fail_count++;
        exp_q.delete();
        beats      = 0;
        run_errors = 0;
    endtask

    task automatic print_totals();
        if (beats != 0 || run_errors != 0) begin
            $display("Result beats arrived after the last done pulse.");
            fail_count++;
        end
        $display("Totals: %0d tests passed, %0d tests failed.", pass_count, fail_count);
    endtask

    // The DUT outputs change on the rising edge, so the falling edge sees them settled.
    always @(negedge clk) begin
        // The run is judged one cycle after done, once busy must have dropped.
        if (!rst && verdict_due) begin
            if (busy) begin
                $display("Test %0d: busy was still high one cycle after done.", done_id);
                run_errors++;
            end
            if (run_errors == 0) begin
                pass_count++;
                $display("Test %0d ok: %0d results matched.", done_id, beats);
            end else begin
                fail_count++;
                $display("Test %0d FAILED with %0d errors.", done_id, run_errors);
            end
            beats       = 0;
            run_errors  = 0;
            verdict_due = 1'b0;
        end
        if (!rst && result_valid) begin
            if (!busy) begin
                $display("Test %0d: busy was low during the result at column %0d.",
                         test_id, result_col);
                run_errors++;
            end
            if (exp_q.size() == 0) begin
                $display("Test %0d: unexpected result beat at column %0d.", test_id, result_col);
                run_errors++;
            end else begin
                expected = exp_q.pop_front();
                if (int'(result) != expected || result_col != col_t'(beats)) begin
                    $display("ERROR at %0d ns: test %0d col %0d expected %0d (col %0d), got %0d",
                             $time, test_id, result_col, expected, beats, int'(result));
                    run_errors++;
                end
            end
            beats++;
        end
        if (!rst && done) begin
            if (beats != RESULTS_PER_RUN) begin
                $display("Test %0d: %0d result beats arrived before done instead of %0d.",
                         test_id, beats, RESULTS_PER_RUN);
                run_errors++;
            end
            for (int i = beats; i < RESULTS_PER_RUN; i++) begin
                if (exp_q.size() > 0) begin
                    expected = exp_q.pop_front();  // Drop what the missing beats owed.
                end
            end
            done_id     = test_id;
            verdict_due = 1'b1;
        end
    end

endmodule

/* verification/conv_tb.sv */
`timescale 1ns/1ps
`include "conv_config.svh"

module conv_tb;
    import conv_pkg::*;

    localparam int IMG_W           = `CONV_IMG_WIDTH;
    localparam int IMG_PIXELS      = `CONV_IMG_WIDTH * `CONV_IMG_HEIGHT;
    localparam int COEF_W          = `CONV_COEF_WIDTH;
    localparam int RESULTS_PER_RUN = IMG_W - 2;
    localparam int NUM_TESTS       = 10;
    localparam int RESET_CYCLES    = 10;
    localparam int DONE_WAIT       = 60;  // A run takes about 31 cycles from start to done.
    // Each run is bounded by a full image load plus the run itself.
    localparam int TIMEOUT_CYCLES  = 2 * (NUM_TESTS * (IMG_PIXELS + 40) + RESET_CYCLES);

    logic    clk;
    logic    rst;
    logic    img_we;
    addr_t   img_waddr;
    pixel_t  img_wdata;
    logic    start;
    row_t    row_num;
    kernel_t kernel;
    acc_t    result;
    col_t    result_col;
    logic    result_valid;
    logic    busy;
    logic    done;

    int      test_id;
    int      seed;
    int      cycle_count;
    int      row;
    pixel_t  image [IMG_PIXELS];  // Model of the image memory contents.
    kernel_t k;

    conv_row_engine i_dut (
        .clk          (clk),
        .rst          (rst),
        .img_we       (img_we),
        .img_waddr    (img_waddr),
        .img_wdata    (img_wdata),
        .start        (start),
        .row_num      (row_num),
        .kernel       (kernel),
        .result       (result),
        .result_col   (result_col),
        .result_valid (result_valid),
        .busy         (busy),
        .done         (done)
    );

    conv_monitor i_mon (
        .clk          (clk),
        .rst          (rst),
        .result       (result),
        .result_col   (result_col),
        .result_valid (result_valid),
        .busy         (busy),
        .done         (done),
        .test_id      (test_id)
    );

    bind load_buffer conv_chk i_chk (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .busy      (busy),
        .done      (done),
        .rd_en     (rd_en),
        .win_valid (win_valid),
        .raddr_top (raddr_top),
        .raddr_mid (raddr_mid),
        .raddr_bot (raddr_bot),
        .state     (state)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Sum of the nine signed products for the window whose top left pixel is (row, col).
    function automatic int conv_ref(input pixel_t img [IMG_PIXELS], input int r, input int col,
                                    input kernel_t kern);
        int    sum;
        int    tap;
        coef_t c;
        sum = 0;
        for (int kr = 0; kr < 3; kr++) begin
            for (int kc = 0; kc < 3; kc++) begin
                tap = kr * 3 + kc;
                c   = kern[(8 - tap) * COEF_W +: COEF_W];  // r0c0 is the top field.
                sum += int'(img[(r + kr) * IMG_W + col + kc]) * int'(c);
            end
        end
        return sum;
    endfunction

    function automatic kernel_t random_kernel();
        kernel_t kern;
        for (int i = 0; i < 9; i++) begin
            kern[i * COEF_W +: COEF_W] = coef_t'($random(seed));
        end
        return kern;
    endfunction

    function automatic kernel_t uniform_kernel(input coef_t c);
        kernel_t kern;
        for (int i = 0; i < 9; i++) begin
            kern[i * COEF_W +: COEF_W] = c;
        end
        return kern;
    endfunction

    task automatic write_pixel(input int addr, input pixel_t value);
        @(posedge clk);
        img_we      <= 1'b1;
        img_waddr   <= addr_t'(addr);
        img_wdata   <= value;
        image[addr] = value;
    endtask

    task automatic stop_writes();
        @(posedge clk);
        img_we <= 1'b0;
    endtask

    task automatic fill_random_image();
        for (int a = 0; a < IMG_PIXELS; a++) begin
            write_pixel(a, pixel_t'($random(seed)));
        end
        stop_writes();
    endtask

    task automatic fill_constant_image(input pixel_t value);
        for (int a = 0; a < IMG_PIXELS; a++) begin
            write_pixel(a, value);
        end
        stop_writes();
    endtask

    task automatic write_random_row(input int r);
        for (int c = 0; c < IMG_W; c++) begin
            write_pixel(r * IMG_W + c, pixel_t'($random(seed)));
        end
        stop_writes();
    endtask

    task automatic queue_reference(input int r, input kernel_t kern);
        for (int c = 0; c < RESULTS_PER_RUN; c++) begin
            i_mon.push_expected(conv_ref(image, r, c, kern));
        end
    endtask

    // With the identity kernel each result is the centre pixel of its window.
    task automatic queue_identity(input int r);
        for (int c = 0; c < RESULTS_PER_RUN; c++) begin
            i_mon.push_expected(int'(image[(r + 1) * IMG_W + c + 1]));
        end
    endtask

    task automatic queue_constant(input int value);
        for (int c = 0; c < RESULTS_PER_RUN; c++) begin
            i_mon.push_expected(value);
        end
    endtask

    task automatic start_run(input int id, input int r, input kernel_t kern);
        @(posedge clk);
        test_id <= id;
        kernel  <= kern;
        row_num <= row_t'(r);
        start   <= 1'b1;
        @(posedge clk);
        start   <= 1'b0;
    endtask

    task automatic wait_done();
        logic seen;
        seen = 1'b0;
        for (int n = 0; n < DONE_WAIT && !seen; n++) begin
            @(negedge clk);
            seen = done;
        end
        if (!seen) begin
            $display("Test %0d: done did not arrive within %0d cycles.", test_id, DONE_WAIT);
            i_mon.record_failure();
        end
    endtask

    initial begin
        seed      = 32'h4c85_bce4;
        rst       = 1'b1;
        img_we    = 1'b0;
        img_waddr = '0;
        img_wdata = '0;
        start     = 1'b0;
        row_num   = '0;
        kernel    = '0;
        test_id   = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        fill_random_image();
        k      = '0;
        k.r1c1 = coef_t'(1);
        start_run(1, 0, k);
        queue_identity(0);
        wait_done();

        // Top, middle and bottom positions, each on a fresh image.
        k = random_kernel();
        for (int i = 0; i < 3; i++) begin
            row = (i == 2) ? 25 : i * 12;
            fill_random_image();
            start_run(2 + i, row, k);
            queue_reference(row, k);
            wait_done();
        end

        fill_constant_image(pixel_t'(255));
        start_run(5, 13, uniform_kernel(coef_t'(-128)));
        queue_constant(-293760);
        wait_done();
        start_run(6, 13, uniform_kernel(coef_t'(127)));
        queue_constant(291465);
        wait_done();

        fill_random_image();
        k = random_kernel();
        start_run(7, 7, k);
        queue_reference(7, k);
        wait_done();
        repeat (10) @(posedge clk);  // The monitor flags any beat that trails done.

        start_run(8, 3, k);
        queue_reference(3, k);
        repeat (4) @(posedge clk);
        row_num <= row_t'(20);
        start   <= 1'b1;
        @(posedge clk);
        start   <= 1'b0;
        wait_done();

        // Row 10 lies outside the first run and feeds the second.
        start_run(9, 5, k);
        queue_reference(5, k);
        write_random_row(10);
        wait_done();
        start_run(10, 9, k);
        queue_reference(9, k);
        wait_done();

        repeat (5) @(posedge clk);
        i_mon.print_totals();
        if (i_dut.i_load.i_chk.assert_failures != 0) begin
            $display("Protocol assertions failed %0d times.", i_dut.i_load.i_chk.assert_failures);
        end
        if (i_mon.fail_count == 0 && i_mon.pass_count == NUM_TESTS &&
            i_dut.i_load.i_chk.assert_failures == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles.", TIMEOUT_CYCLES);
        $display("Checks failed");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+hw
hw/conv_pkg.sv
hw/image_mem.sv
hw/load_buffer.sv
hw/conv_window_mac.sv
hw/conv_row_engine.sv
verification/conv_chk.sv
verification/conv_monitor.sv
verification/conv_tb.sv

/* Bender.yml */
package:
  name: conv_row_engine

sources:
  - include_dirs:
      - hw
    files:
      - hw/conv_pkg.sv
      - hw/image_mem.sv
      - hw/load_buffer.sv
      - hw/conv_window_mac.sv
      - hw/conv_row_engine.sv

  - target: simulation
    include_dirs:
      - hw
    files:
      - verification/conv_chk.sv
      - verification/conv_monitor.sv
      - verification/conv_tb.sv
